/* Bender.yml */
package:
  name: mem_stage

sources:
  - files:
      - design/mem_stage_pkg.sv
      - design/mem_access_ctrl.sv
      - design/load_extend.sv
      - design/data_ram.sv
      - design/mem_stage_pipe.sv
      - design/mem_stage.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_mem_stage.sv

/* design/data_ram.sv */
`timescale 1ns/100ps
`default_nettype none

module data_ram #(
    parameter int RAM_WORDS = 256
) (
    input  logic                         clk,
    input  logic                         en,
    input  logic [3:0]                   we,
    input  logic [$clog2(RAM_WORDS)-1:0] index,
    input  logic [31:0]                  wdata,
    output logic [31:0]                  rdata
);

    logic [31:0] mem [RAM_WORDS];

    initial begin
        for (int i = 0; i < RAM_WORDS; i++) begin
            mem[i] = 32'b0;
        end
    end

    // Read returns the word as it was before this edge's write.
    always_ff @(posedge clk) begin
        if (en) begin
            rdata <= mem[index];
        end
    end

    // Byte-lane writes.
    always_ff @(posedge clk) begin
        if (en) begin
            for (int b = 0; b < 4; b++) begin
                if (we[b]) begin
                    mem[index][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* design/load_extend.sv */
`timescale 1ns/100ps
`default_nettype none

module load_extend
    import mem_stage_pkg::*;
(
    input  access_t     acc,
    input  logic [31:0] ram_rdata,
    output logic [31:0] load_data
);

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    // Lane select.
    always_comb begin
        case (acc.lane)
            2'd0:    byte_sel = ram_rdata[7:0];
            2'd1:    byte_sel = ram_rdata[15:8];
            2'd2:    byte_sel = ram_rdata[23:16];
            default: byte_sel = ram_rdata[31:24];
        endcase
    end

    assign half_sel = acc.lane[1] ? ram_rdata[31:16] : ram_rdata[15:0];

    // Extension.
    always_comb begin
        case (acc.size)
            SIZE_BYTE: begin
                if (acc.is_unsigned) begin
                    load_data = {24'b0, byte_sel};
                end else begin
                    load_data = {{24{byte_sel[7]}}, byte_sel};
                end
            end
            SIZE_HALF: begin
                if (acc.is_unsigned) begin
                    load_data = {16'b0, half_sel};
                end else begin
                    load_data = {{16{half_sel[15]}}, half_sel};
                end
            end
            default: begin
                load_data = ram_rdata;   // Word passes through.
            end
        endcase
    end

endmodule

`default_nettype wire

/* design/mem_access_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_access_ctrl
    import mem_stage_pkg::*;
(
    input  mem_req_t    req,
    output access_t     acc,
    output logic        misaligned,
    output logic [3:0]  byte_wen,
    output logic [31:0] ram_wdata
);

    logic known_op;
    logic addr_bad;

    // Opcode classification.
    always_comb begin
        acc.is_load     = 1'b0;
        acc.is_store    = 1'b0;
        acc.size        = SIZE_WORD;
        acc.is_unsigned = 1'b0;
        acc.lane        = req.addr[1:0];
        known_op        = 1'b1;
        case (req.op)
            OP_LB: begin
                acc.is_load = 1'b1;
                acc.size    = SIZE_BYTE;
            end
            OP_LBU: begin
                acc.is_load     = 1'b1;
                acc.size        = SIZE_BYTE;
                acc.is_unsigned = 1'b1;   // Zero-extended, unlike LB.
            end
            OP_LH: begin
                acc.is_load = 1'b1;
                acc.size    = SIZE_HALF;
            end
            OP_LHU: begin
                acc.is_load     = 1'b1;
                acc.size        = SIZE_HALF;
                acc.is_unsigned = 1'b1;
            end
            OP_LW: begin
                acc.is_load = 1'b1;
            end
            OP_SB: begin
                acc.is_store = 1'b1;
                acc.size     = SIZE_BYTE;
            end
            OP_SH: begin
                acc.is_store = 1'b1;
                acc.size     = SIZE_HALF;
            end
            OP_SW: begin
                acc.is_store = 1'b1;
            end
            default: begin
                known_op = 1'b0;
            end
        endcase
    end

    // Alignment check on the low address bits.
    always_comb begin
        case (acc.size)
            SIZE_HALF: addr_bad = req.addr[0];
            SIZE_WORD: addr_bad = |req.addr[1:0];
            default:   addr_bad = 1'b0;
        endcase
    end

    // Unknown opcodes share the flag, it is the request error.
    assign misaligned = addr_bad | ~known_op;

    // Byte enables, only for a clean store.
    always_comb begin
        byte_wen = 4'b0000;
        if (acc.is_store && !misaligned) begin
            case (acc.size)
                SIZE_BYTE: byte_wen = 4'b0001 << acc.lane;
                SIZE_HALF: byte_wen = acc.lane[1] ? 4'b1100 : 4'b0011;
                default:   byte_wen = 4'b1111;
            endcase
        end
    end

    // The RAM is word wide, so narrow data goes to every lane.
    always_comb begin
        case (acc.size)
            SIZE_BYTE: ram_wdata = {4{req.wdata[7:0]}};
            SIZE_HALF: ram_wdata = {2{req.wdata[15:0]}};
            default:   ram_wdata = req.wdata;
        endcase
    end

endmodule

`default_nettype wire

/* design/mem_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_stage
    import mem_stage_pkg::*;
#(
    parameter int RAM_WORDS = 256   // Power of two.
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     req_valid,
    input  mem_req_t req,
    input  logic     rsp_ready,
    output logic     req_ready,
    output logic     rsp_valid,
    output mem_rsp_t rsp
);

    access_t                      acc;
    access_t                      acc_q;
    logic                         misaligned;
    logic [3:0]                   byte_wen;
    logic [31:0]                  ram_wdata;
    logic                         ram_en;
    logic [3:0]                   ram_we;
    logic [$clog2(RAM_WORDS)-1:0] ram_index;
    logic [31:0]                  ram_rdata;
    logic [31:0]                  load_data;

    mem_access_ctrl ctrl0 (
        .req        (req),
        .acc        (acc),
        .misaligned (misaligned),
        .byte_wen   (byte_wen),
        .ram_wdata  (ram_wdata)
    );

    mem_stage_pipe #(
        .RAM_WORDS (RAM_WORDS)
    ) pipe0 (
        .clk        (clk),
        .arst_n     (arst_n),
        .req_valid  (req_valid),
        .req_addr   (req.addr),
        .acc        (acc),
        .misaligned (misaligned),
        .byte_wen   (byte_wen),
        .rsp_ready  (rsp_ready),
        .load_data  (load_data),
        .req_ready  (req_ready),
        .ram_en     (ram_en),
        .ram_we     (ram_we),
        .ram_index  (ram_index),
        .acc_q      (acc_q),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp)
    );

    data_ram #(
        .RAM_WORDS (RAM_WORDS)
    ) ram0 (
        .clk   (clk),
        .en    (ram_en),
        .we    (ram_we),
        .index (ram_index),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

    load_extend ext0 (
        .acc       (acc_q),
        .ram_rdata (ram_rdata),
        .load_data (load_data)
    );

endmodule

`default_nettype wire

/* design/mem_stage_pipe.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_stage_pipe
    import mem_stage_pkg::*;
#(
    parameter int RAM_WORDS = 256
) (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         req_valid,
    input  logic [31:0]                  req_addr,
    input  access_t                      acc,
    input  logic                         misaligned,
    input  logic [3:0]                   byte_wen,
    input  logic                         rsp_ready,
    input  logic [31:0]                  load_data,
    output logic                         req_ready,
    output logic                         ram_en,
    output logic [3:0]                   ram_we,
    output logic [$clog2(RAM_WORDS)-1:0] ram_index,
    output access_t                      acc_q,
    output logic                         rsp_valid,
    output mem_rsp_t                     rsp
);

    localparam int IDX_W = $clog2(RAM_WORDS);

    logic accept;
    logic err_q;

    // Slot is free when empty or being drained this cycle.
    assign req_ready = ~rsp_valid | rsp_ready;
    assign accept    = req_valid & req_ready;

    // A failed request never reaches the RAM.
    assign ram_en    = accept & ~misaligned;
    assign ram_we    = byte_wen & {4{ram_en}};
    assign ram_index = req_addr[IDX_W+1:2];   // Word index, wraps at depth.

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_valid <= 1'b0;
        end else if (req_ready) begin
            rsp_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            acc_q <= acc;
            err_q <= misaligned;
        end
    end

    // RAM output is held until the next accept, so rsp stays stable.
    always_comb begin
        rsp.is_store = acc_q.is_store;
        rsp.error    = err_q;
        if (acc_q.is_load && !err_q) begin
            rsp.rdata = load_data;
        end else begin
            rsp.rdata = 32'b0;
        end
    end

endmodule

`default_nettype wire

/* design/mem_stage_pkg.sv */
`default_nettype none

package mem_stage_pkg;

    // MIPS load and store opcodes, instr[31:26].
    localparam logic [5:0] OP_LB  = 6'b100000;
    localparam logic [5:0] OP_LH  = 6'b100001;
    localparam logic [5:0] OP_LW  = 6'b100011;
    localparam logic [5:0] OP_LBU = 6'b100100;
    localparam logic [5:0] OP_LHU = 6'b100101;
    localparam logic [5:0] OP_SB  = 6'b101000;
    localparam logic [5:0] OP_SH  = 6'b101001;
    localparam logic [5:0] OP_SW  = 6'b101011;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } access_size_e;

    // Decoded access, 7 bits.
    typedef struct packed {
        logic         is_load;
        logic         is_store;
        access_size_e size;
        logic         is_unsigned;
        logic [1:0]   lane;      // Address bits [1:0].
    } access_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [31:0] addr;
        logic [31:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        is_store;
        logic        error;
    } mem_rsp_t;

endpackage

`default_nettype wire

/* files.f */
+incdir+test
design/mem_stage_pkg.sv
design/mem_access_ctrl.sv
design/load_extend.sv
design/data_ram.sv
design/mem_stage_pipe.sv
design/mem_stage.sv
test/tb_mem_stage.sv

/* test/tb_mem_model.svh */
`ifndef TB_MEM_MODEL_SVH
`define TB_MEM_MODEL_SVH

localparam int SHADOW_BYTES = 4 * TB_RAM_WORDS;
localparam int SHADOW_AW    = $clog2(SHADOW_BYTES);

logic [7:0] shadow_mem [SHADOW_BYTES];   // Little-endian byte image of the RAM.

function automatic void clear_shadow();
    for (int i = 0; i < SHADOW_BYTES; i++) begin
        shadow_mem[i] = 8'h00;
    end
endfunction

// Expected response for one request. Clean stores also update the shadow memory.
function automatic mem_rsp_t expected_response(input mem_req_t r);
    mem_rsp_t    rsp;
    int          base;
    int          nbytes;
    logic        is_load;
    logic        sign_ext;
    logic [31:0] word;
    base = int'(r.addr[SHADOW_AW-1:0]);   // RAM index wraps at its depth.
    rsp  = '0;
    case (r.op)
        OP_LB, OP_LBU, OP_SB: nbytes = 1;
        OP_LH, OP_LHU, OP_SH: nbytes = 2;
        OP_LW, OP_SW:         nbytes = 4;
        default:              nbytes = 0;
    endcase
    is_load      = (r.op == OP_LB) || (r.op == OP_LBU) || (r.op == OP_LH)
                   || (r.op == OP_LHU) || (r.op == OP_LW);
    sign_ext     = (r.op == OP_LB) || (r.op == OP_LH);
    rsp.is_store = (r.op == OP_SB) || (r.op == OP_SH) || (r.op == OP_SW);
    if (nbytes == 0) begin
        rsp.error = 1'b1;
    end else begin
        rsp.error = (int'(r.addr[1:0]) % nbytes) != 0;
    end
    if (!rsp.error && rsp.is_store) begin
        for (int i = 0; i < nbytes; i++) begin
            shadow_mem[base + i] = r.wdata[8*i +: 8];
        end
    end else if (!rsp.error && is_load) begin
        word = 32'h0;
        for (int i = 0; i < nbytes; i++) begin
            word[8*i +: 8] = shadow_mem[base + i];
        end
        if (sign_ext && word[8*nbytes-1]) begin
            for (int b = 8 * nbytes; b < 32; b++) begin
                word[b] = 1'b1;
            end
        end
        rsp.rdata = word;
    end
    return rsp;
endfunction

`endif

/* test/tb_mem_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_mem_stage
    import mem_stage_pkg::*;
;

    localparam int TB_RAM_WORDS   = 64;
    localparam int N_STORE_WORDS  = 16;
    localparam int N_RANDOM       = 400;
    // Requests of the directed phases come to 24, 26 and 15 after the SW/LW pairs.
    localparam int TOTAL_REQS     = 2 * N_STORE_WORDS + 24 + 26 + 15 + N_RANDOM;
    localparam int TIMEOUT_CYCLES = 4 * TOTAL_REQS + 200;

    logic     clk;
    logic     arst_n;
    logic     req_valid;
    mem_req_t req;
    logic     rsp_ready;
    logic     req_ready;
    logic     rsp_valid;
    mem_rsp_t rsp;

    logic        bp_on;
    logic        accept_seen;
    mem_rsp_t    exp_q [$];
    mem_rsp_t    exp_rsp;
    int          checks;
    int          value_errs;
    int          proto_errs;
    int          cycles;
    logic [31:0] p1_addr [N_STORE_WORDS];

    `include "tb_mem_model.svh"

    mem_stage #(
        .RAM_WORDS (TB_RAM_WORDS)
    ) dut0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .req_valid (req_valid),
        .req       (req),
        .rsp_ready (rsp_ready),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Drives a request after a rising edge and returns on the edge that accepts it.
    task automatic send_req(input logic [5:0] op, input logic [31:0] addr,
                            input logic [31:0] wdata);
        req_valid <= 1'b1;
        req       <= {op, addr, wdata};
        @(negedge clk);
        while (!req_ready) @(negedge clk);
        @(posedge clk);
    endtask

    task automatic send_then_reload(input logic [5:0] op, input logic [31:0] addr,
                                    input logic [31:0] base);
        send_req(op, addr, 32'hdead_beef);
        send_req(OP_LW, base, 32'h0);
    endtask

    always @(posedge clk) begin
        if (bp_on) begin
            rsp_ready <= ($urandom_range(0, 3) != 0);
        end else begin
            rsp_ready <= 1'b1;
        end
    end

    // Each response is checked mid-cycle before its handshake edge.
    always @(negedge clk) begin
        if (!arst_n) begin
            accept_seen = 1'b0;
        end else begin
            if (accept_seen && !rsp_valid) begin
                $display("Response not valid one cycle after its request was accepted");
                proto_errs++;
            end
            if (rsp_valid && exp_q.size() == 0) begin
                $display("Response valid with no request outstanding");
                proto_errs++;
            end else if (rsp_valid && rsp_ready) begin
                exp_rsp = exp_q.pop_front();
                checks++;
                if (rsp.rdata !== exp_rsp.rdata) begin
                    $display("[FAIL] rsp.rdata: got %08h, expected %08h (response %0d)",
                             rsp.rdata, exp_rsp.rdata, checks);
                    value_errs++;
                end
                if (rsp.is_store !== exp_rsp.is_store) begin
                    $display("[FAIL] rsp.is_store: got %h, expected %h (response %0d)",
                             rsp.is_store, exp_rsp.is_store, checks);
                    value_errs++;
                end
                if (rsp.error !== exp_rsp.error) begin
                    $display("[FAIL] rsp.error: got %h, expected %h (response %0d)",
                             rsp.error, exp_rsp.error, checks);
                    value_errs++;
                end
            end
            accept_seen = req_valid && req_ready;
            if (accept_seen) begin
                exp_q.push_back(expected_response(req));
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Responses checked: %0d, value errors: %0d, protocol errors: %0d",
                 checks, value_errs, proto_errs);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        logic [5:0]  op;
        logic [31:0] addr;
        logic [31:0] base;
        void'($urandom(32'h5b7f6bfa));
        arst_n      = 1'b0;
        req_valid   = 1'b0;
        req         = '0;
        rsp_ready   = 1'b0;
        bp_on       = 1'b0;
        accept_seen = 1'b0;
        checks      = 0;
        value_errs  = 0;
        proto_errs  = 0;
        clear_shadow();
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        if (rsp_valid || !req_ready) begin
            $display("Handshake outputs wrong after reset release");
            proto_errs++;
        end
        @(posedge clk);

        // Word stores then reads over full 32-bit addresses.
        for (int i = 0; i < N_STORE_WORDS; i++) begin
            p1_addr[i] = $urandom() & 32'hffff_fffc;
            send_req(OP_SW, p1_addr[i], $urandom());
        end
        for (int i = 0; i < N_STORE_WORDS; i++) begin
            send_req(OP_LW, p1_addr[i], 32'h0);
        end

        // Partial stores per lane.
        for (int w = 0; w < 2; w++) begin
            base = 32'h0000_0010 + 4 * w;
            for (int lane = 0; lane < 4; lane++) begin
                send_req(OP_SB, base + lane, $urandom());
                send_req(OP_LW, base, 32'h0);
            end
            for (int h = 0; h < 2; h++) begin
                send_req(OP_SH, base + 2 * h, $urandom());
                send_req(OP_LW, base, 32'h0);
            end
        end

        // Narrow loads with and without the top bit set.
        for (int w = 0; w < 2; w++) begin
            base = 32'h0000_0040 + 4 * w;
            send_req(OP_SW, base, (w == 0) ? 32'hf07f_8a15 : 32'h7ec3_01ff);
            for (int lane = 0; lane < 4; lane++) begin
                send_req(OP_LB, base + lane, 32'h0);
                send_req(OP_LBU, base + lane, 32'h0);
            end
            for (int h = 0; h < 2; h++) begin
                send_req(OP_LH, base + 2 * h, 32'h0);
                send_req(OP_LHU, base + 2 * h, 32'h0);
            end
        end

        // Misaligned and unknown requests must leave memory alone.
        base = 32'h0000_0020;
        send_req(OP_SW, base, 32'h1234_5678);
        send_then_reload(OP_LW, base + 1, base);
        send_then_reload(OP_LW, base + 2, base);
        send_then_reload(OP_SW, base + 3, base);
        send_then_reload(OP_LH, base + 1, base);
        send_then_reload(OP_SH, base + 3, base);
        send_then_reload(OP_SH, base + 1, base);
        send_then_reload(6'b001000, base, base);   // ADDI.

        // Random mix under random back-pressure.
        bp_on <= 1'b1;
        for (int n = 0; n < N_RANDOM; n++) begin
            if ($urandom_range(0, 1) != 0) begin
                req_valid <= 1'b0;
                @(posedge clk);
            end
            case ($urandom_range(0, 8))
                0: op = OP_LB;
                1: op = OP_LBU;
                2: op = OP_LH;
                3: op = OP_LHU;
                4: op = OP_LW;
                5: op = OP_SB;
                6: op = OP_SH;
                7: op = OP_SW;
                default: op = 6'b001111;   // LUI.
            endcase
            addr = $urandom();
            if ($urandom_range(0, 3) != 0) begin
                if (op == OP_LW || op == OP_SW) begin
                    addr[1:0] = 2'b00;
                end else if (op == OP_LH || op == OP_LHU || op == OP_SH) begin
                    addr[0] = 1'b0;
                end
            end
            send_req(op, addr, $urandom());
        end

        req_valid <= 1'b0;
        bp_on     <= 1'b0;
        while (exp_q.size() != 0) @(posedge clk);
        repeat (2) @(posedge clk);
        $display("Responses checked: %0d, value errors: %0d, protocol errors: %0d",
                 checks, value_errs, proto_errs);
        if (value_errs == 0 && proto_errs == 0 && checks == TOTAL_REQS) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
